/* rtl/eFpgaCfgPkg.sv */
package eFpgaCfgPkg;

	localparam int FrameBitsPerRow = 32;	// one frame word, one row register
	localparam int FrameSelectWidth = 5;	// column field at the top of the FAR
	localparam int RowSelectWidth = 5;

	// config words, the FAR and row data all share this width
	typedef logic [FrameBitsPerRow-1:0] cfgWord_t;

	typedef logic [FrameSelectWidth-1:0] colSel_t;
	typedef logic [RowSelectWidth-1:0] rowSel_t;
	typedef logic [31:0] wbAddr_t;

	// the sequencer takes the FAR first and then one word per row
	typedef enum logic {
		SeqFar,
		SeqRows
	} seqState_e;

endpackage

/* rtl/frameBusIf.sv */
`timescale 1ns/1ps

interface frameBusIf #(
	parameter int NumberOfRows = 4
);

	logic writeStrobe;
	eFpgaCfgPkg::rowSel_t rowSelect;
	eFpgaCfgPkg::cfgWord_t writeData;
	logic longFrameStrobe;
	eFpgaCfgPkg::cfgWord_t far;	// frame address register
	logic lastRow;

	// high while the row write targets the last row of a frame
	assign lastRow = (rowSelect == eFpgaCfgPkg::rowSel_t'(NumberOfRows - 1));

	modport seq (
		output writeStrobe, rowSelect, writeData, longFrameStrobe, far,
		input lastRow
	);
	modport store (input writeStrobe, rowSelect, writeData, longFrameStrobe, far);
	modport monitor (input far);

endinterface

/* rtl/wbConfigPort.sv */
`timescale 1ns/1ps

module wbConfigPort #(
	parameter eFpgaCfgPkg::wbAddr_t CfgAddr = 32'h3000_0000
) (
	input logic wb_clk_i,
	input logic rstN_i,
	input logic wbsStb_i,
	input logic wbsCyc_i,
	input logic wbsWe_i,
	input logic [eFpgaCfgPkg::FrameBitsPerRow/8-1:0] wbsSel_i,
	input eFpgaCfgPkg::wbAddr_t wbsAdr_i,
	input eFpgaCfgPkg::cfgWord_t wbsDat_i,
	output logic wbsAck_o,
	output eFpgaCfgPkg::cfgWord_t wbsDat_o,
	output logic req_o,
	input logic gnt_i,
	output eFpgaCfgPkg::cfgWord_t word_o,
	frameBusIf.monitor frame
);

	logic busHit;
	logic isCfg;
	logic cfgWrite;
	logic accept;	// new bus cycle can be taken

	assign busHit = wbsStb_i && wbsCyc_i;
	assign isCfg = (wbsAdr_i == CfgAddr);
	assign cfgWrite = busHit && wbsWe_i && isCfg && (&wbsSel_i);	// full word only
	// the ack cycle still shows stb, so skip it and any pending request
	assign accept = busHit && !req_o && !wbsAck_o;

	always_ff @(posedge wb_clk_i) begin
		if (!rstN_i) begin
			req_o <= 1'b0;
			wbsAck_o <= 1'b0;
		end else begin
			wbsAck_o <= 1'b0;
			if (req_o) begin
				if (gnt_i) begin
					req_o <= 1'b0;
					wbsAck_o <= 1'b1;	// config write done once granted
				end
			end else if (accept) begin
				if (cfgWrite)
					req_o <= 1'b1;
				else
					wbsAck_o <= 1'b1;	// reads and ignored writes
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			word_o <= wbsDat_i;	// held steady while req_o is up
			wbsDat_o <= isCfg ? frame.far : '0;
		end
	end

endmodule

/* rtl/bitbangLoader.sv */
`timescale 1ns/1ps

module bitbangLoader (
	input logic wb_clk_i,
	input logic rstN_i,
	input logic sClk_i,
	input logic sData_i,
	output logic req_o,
	input logic gnt_i,
	output eFpgaCfgPkg::cfgWord_t word_o
);

	localparam int CntWidth = $clog2(eFpgaCfgPkg::FrameBitsPerRow);

	logic [2:0] sClkSync;	// two sync stages plus one for the edge
	logic [1:0] sDataSync;
	logic sClkRise;
	logic [CntWidth-1:0] bitCnt;
	logic wordDone;
	eFpgaCfgPkg::cfgWord_t shiftReg;

	assign sClkRise = sClkSync[1] && !sClkSync[2];
	assign wordDone = sClkRise && (bitCnt == CntWidth'(eFpgaCfgPkg::FrameBitsPerRow - 1));

	always_ff @(posedge wb_clk_i) begin
		if (!rstN_i) begin
			sClkSync <= '0;
			sDataSync <= '0;
			bitCnt <= '0;
			req_o <= 1'b0;
		end else begin
			sClkSync <= {sClkSync[1:0], sClk_i};
			sDataSync <= {sDataSync[0], sData_i};
			if (sClkRise)
				bitCnt <= bitCnt + 1'b1;	// wraps after the last bit
			if (wordDone)
				req_o <= 1'b1;
			else if (gnt_i)
				req_o <= 1'b0;
		end
	end

	// msb first
	always_ff @(posedge wb_clk_i) begin
		if (sClkRise)
			shiftReg <= {shiftReg[eFpgaCfgPkg::FrameBitsPerRow-2:0], sDataSync[1]};
		if (wordDone)
			word_o <= {shiftReg[eFpgaCfgPkg::FrameBitsPerRow-2:0], sDataSync[1]};
	end

endmodule

/* rtl/configArbiter.sv */
`timescale 1ns/1ps

module configArbiter (
	input logic wb_clk_i,
	input logic rstN_i,
	input logic wbReq_i,
	input eFpgaCfgPkg::cfgWord_t wbWord_i,
	output logic wbGnt_o,
	input logic bbReq_i,
	input eFpgaCfgPkg::cfgWord_t bbWord_i,
	output logic bbGnt_o,
	output logic cfgStrobe_o,
	output eFpgaCfgPkg::cfgWord_t cfgData_o
);

	logic bbWonLast;	// set at reset so wishbone wins the first tie
	logic pickBb;

	// one idle cycle between words keeps the FAR stable through the long strobe
	always_comb begin
		pickBb = bbReq_i && (!wbReq_i || !bbWonLast);
		wbGnt_o = wbReq_i && !pickBb && !cfgStrobe_o;
		bbGnt_o = pickBb && !cfgStrobe_o;
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rstN_i) begin
			bbWonLast <= 1'b1;
			cfgStrobe_o <= 1'b0;
		end else begin
			cfgStrobe_o <= wbGnt_o || bbGnt_o;
			if (wbGnt_o)
				bbWonLast <= 1'b0;
			else if (bbGnt_o)
				bbWonLast <= 1'b1;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (wbGnt_o)
			cfgData_o <= wbWord_i;
		else if (bbGnt_o)
			cfgData_o <= bbWord_i;
	end

endmodule

/* rtl/frameSequencer.sv */
`timescale 1ns/1ps

module frameSequencer #(
	parameter int NumberOfRows = 4
) (
	input logic wb_clk_i,
	input logic rstN_i,
	input logic cfgStrobe_i,
	input eFpgaCfgPkg::cfgWord_t cfgData_i,
	frameBusIf.seq frame
);

	eFpgaCfgPkg::seqState_e state;
	eFpgaCfgPkg::rowSel_t rowCnt;	// next row to be written

	always_ff @(posedge wb_clk_i) begin
		if (!rstN_i) begin
			state <= eFpgaCfgPkg::SeqFar;
			rowCnt <= '0;
			frame.writeStrobe <= 1'b0;
			frame.rowSelect <= '0;
			frame.longFrameStrobe <= 1'b0;
			frame.far <= '0;
		end else begin
			frame.writeStrobe <= 1'b0;
			// fires once the last row register has taken its word
			frame.longFrameStrobe <= frame.writeStrobe && frame.lastRow;
			if (cfgStrobe_i) begin
				case (state)
					eFpgaCfgPkg::SeqFar: begin
						frame.far <= cfgData_i;
						rowCnt <= '0;
						state <= eFpgaCfgPkg::SeqRows;
					end
					eFpgaCfgPkg::SeqRows: begin
						frame.writeStrobe <= 1'b1;
						frame.rowSelect <= rowCnt;
						if (rowCnt == eFpgaCfgPkg::rowSel_t'(NumberOfRows - 1))
							state <= eFpgaCfgPkg::SeqFar;
						else
							rowCnt <= rowCnt + 1'b1;
					end
					default: state <= eFpgaCfgPkg::SeqFar;
				endcase
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (cfgStrobe_i && state == eFpgaCfgPkg::SeqRows)
			frame.writeData <= cfgData_i;
	end

endmodule

/* rtl/frameStore.sv */
`timescale 1ns/1ps

module frameStore #(
	parameter int NumberOfRows = 4,
	parameter int NumberOfCols = 4,
	parameter int MaxFramesPerCol = 8
) (
	input logic wb_clk_i,
	input logic rstN_i,
	frameBusIf.store frame,
	output logic [NumberOfRows*eFpgaCfgPkg::FrameBitsPerRow-1:0] frameData_o,
	output logic [NumberOfCols*MaxFramesPerCol-1:0] frameStrobe_o
);

	localparam int WordBits = eFpgaCfgPkg::FrameBitsPerRow;

	eFpgaCfgPkg::colSel_t colSel;

	assign colSel = frame.far[WordBits-1 -: eFpgaCfgPkg::FrameSelectWidth];

	for (genvar r = 0; r < NumberOfRows; r++) begin : gRow
		eFpgaCfgPkg::cfgWord_t rowReg;

		always_ff @(posedge wb_clk_i) begin
			if (!rstN_i)
				rowReg <= '0;
			else if (frame.writeStrobe && frame.rowSelect == eFpgaCfgPkg::rowSel_t'(r))
				rowReg <= frame.writeData;
		end

		assign frameData_o[r*WordBits +: WordBits] = rowReg;	// row 0 in the low bits
	end

	// a column index past the last column matches nothing
	for (genvar c = 0; c < NumberOfCols; c++) begin : gCol
		assign frameStrobe_o[c*MaxFramesPerCol +: MaxFramesPerCol] =
			(frame.longFrameStrobe && colSel == eFpgaCfgPkg::colSel_t'(c)) ?
			frame.far[MaxFramesPerCol-1:0] : '0;
	end

endmodule

/* rtl/eFpgaConfigTop.sv */
`timescale 1ns/1ps

module eFpgaConfigTop #(
	parameter int NumberOfRows = 4,
	parameter int NumberOfCols = 4,
	parameter int MaxFramesPerCol = 8,
	parameter eFpgaCfgPkg::wbAddr_t CfgAddr = 32'h3000_0000
) (
	input logic wb_clk_i,
	input logic rstN_i,
	// wishbone slave
	input logic wbsStb_i,
	input logic wbsCyc_i,
	input logic wbsWe_i,
	input logic [eFpgaCfgPkg::FrameBitsPerRow/8-1:0] wbsSel_i,
	input eFpgaCfgPkg::wbAddr_t wbsAdr_i,
	input eFpgaCfgPkg::cfgWord_t wbsDat_i,
	output logic wbsAck_o,
	output eFpgaCfgPkg::cfgWord_t wbsDat_o,
	// bit-bang pins
	input logic sClk_i,
	input logic sData_i,
	// to the fabric
	output logic [NumberOfRows*eFpgaCfgPkg::FrameBitsPerRow-1:0] frameData_o,
	output logic [NumberOfCols*MaxFramesPerCol-1:0] frameStrobe_o
);

	logic wbReq, wbGnt, bbReq, bbGnt, cfgStrobe;
	eFpgaCfgPkg::cfgWord_t wbWord, bbWord, cfgData;

	frameBusIf #(.NumberOfRows(NumberOfRows)) frameBus ();

	wbConfigPort #(.CfgAddr(CfgAddr)) wbPort_i (
		.wb_clk_i, .rstN_i, .wbsStb_i, .wbsCyc_i, .wbsWe_i, .wbsSel_i, .wbsAdr_i,
		.wbsDat_i, .wbsAck_o, .wbsDat_o,
		.req_o(wbReq), .gnt_i(wbGnt), .word_o(wbWord), .frame(frameBus.monitor)
	);

	bitbangLoader bbLoader_i (
		.wb_clk_i, .rstN_i, .sClk_i, .sData_i,
		.req_o(bbReq), .gnt_i(bbGnt), .word_o(bbWord)
	);

	configArbiter arbiter_i (
		.wb_clk_i, .rstN_i,
		.wbReq_i(wbReq), .wbWord_i(wbWord), .wbGnt_o(wbGnt),
		.bbReq_i(bbReq), .bbWord_i(bbWord), .bbGnt_o(bbGnt),
		.cfgStrobe_o(cfgStrobe), .cfgData_o(cfgData)
	);

	frameSequencer #(.NumberOfRows(NumberOfRows)) sequencer_i (
		.wb_clk_i, .rstN_i, .cfgStrobe_i(cfgStrobe), .cfgData_i(cfgData),
		.frame(frameBus.seq)
	);

	frameStore #(
		.NumberOfRows(NumberOfRows),
		.NumberOfCols(NumberOfCols),
		.MaxFramesPerCol(MaxFramesPerCol)
	) store_i (
		.wb_clk_i, .rstN_i, .frame(frameBus.store), .frameData_o, .frameStrobe_o
	);

endmodule

/* sim/clkGen.sv */
`timescale 1ns/1ps

module clkGen #(
	parameter int ResetCycles = 5
) (
	output logic clk_o,
	output logic rstN_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;	// 8 ns period
	end

	initial begin
		rstN_o = 1'b0;
		repeat (ResetCycles) @(posedge clk_o);
		@(negedge clk_o);
		rstN_o = 1'b1;	// released on a falling edge like the other inputs
	end

endmodule

/* sim/frameSequencer_checker.sv */
`timescale 1ns/1ps

module frameSequencer_checker (
	input logic clk_i,
	input logic rstN_i,
	input logic wbReq_i,
	input logic wbGnt_i,
	input logic bbReq_i,
	input logic bbGnt_i,
	input logic seqFar_i,
	input logic writeStrobe_i,
	input logic longFrameStrobe_i
);

	// at most one source wins a cycle
	grantOneHot: assert property (@(posedge clk_i) disable iff (!rstN_i)
		!(wbGnt_i && bbGnt_i))
		else $error("wishbone and bit-bang grants high in the same cycle");

	wbReqHeld: assert property (@(posedge clk_i) disable iff (!rstN_i)
		wbReq_i && !wbGnt_i |=> wbReq_i)
		else $error("wishbone request dropped before its grant");

	bbReqHeld: assert property (@(posedge clk_i) disable iff (!rstN_i)
		bbReq_i && !bbGnt_i |=> bbReq_i)
		else $error("bit-bang request dropped before its grant");

	longStrobeSingle: assert property (@(posedge clk_i) disable iff (!rstN_i)
		longFrameStrobe_i |=> !longFrameStrobe_i)
		else $error("long frame strobe held longer than one cycle");

	// a FAR word never turns into a row write
	noWriteFromFar: assert property (@(posedge clk_i) disable iff (!rstN_i)
		seqFar_i |=> !writeStrobe_i)
		else $error("row write strobe raised while waiting for the FAR");

endmodule

// arbiter side only with the sequencer inputs tied low
bind configArbiter frameSequencer_checker arbChk_i (
	.clk_i(wb_clk_i),
	.rstN_i,
	.wbReq_i,
	.wbGnt_i(wbGnt_o),
	.bbReq_i,
	.bbGnt_i(bbGnt_o),
	.seqFar_i(1'b0),
	.writeStrobe_i(1'b0),
	.longFrameStrobe_i(1'b0)
);

bind frameSequencer frameSequencer_checker seqChk_i (
	.clk_i(wb_clk_i),
	.rstN_i,
	.wbReq_i(1'b0),
	.wbGnt_i(1'b0),
	.bbReq_i(1'b0),
	.bbGnt_i(1'b0),
	.seqFar_i(state == eFpgaCfgPkg::SeqFar),
	.writeStrobe_i(frame.writeStrobe),
	.longFrameStrobe_i(frame.longFrameStrobe)
);

/* sim/eFpgaConfigTb.sv */
`timescale 1ns/1ps

module eFpgaConfigTb;

	localparam int NumRows = 4;
	localparam int NumCols = 4;
	localparam int FramesPerCol = 8;
	localparam eFpgaCfgPkg::wbAddr_t CfgAddr = 32'h3000_0000;
	localparam int WordBits = eFpgaCfgPkg::FrameBitsPerRow;
	localparam int DataBits = NumRows * WordBits;
	localparam int StrobeBits = NumCols * FramesPerCol;
	localparam int NumFrames = 5;
	localparam int ProbeIdx = 4;	// bus reads and the partial write go before this frame
	localparam bit SrcWb = 1'b0;
	localparam bit SrcBb = 1'b1;
	localparam int SerialSettle = 5;	// synchronizer, edge detect and grant
	localparam int WatchdogCycles = NumFrames * (NumRows + 1) * 32 * 4 + 1000;

	logic clk;
	logic rstN;
	logic wbsStb;
	logic wbsCyc;
	logic wbsWe;
	logic [WordBits/8-1:0] wbsSel;
	eFpgaCfgPkg::wbAddr_t wbsAdr;
	eFpgaCfgPkg::cfgWord_t wbsDatIn;
	eFpgaCfgPkg::cfgWord_t wbsDatOut;
	logic wbsAck;
	logic sClk;
	logic sData;
	logic [DataBits-1:0] frameData;
	logic [StrobeBits-1:0] frameStrobe;

	// stimulus table where expData doubles as the row words sent
	bit farSrc [NumFrames];
	bit rowSrc [NumFrames];
	eFpgaCfgPkg::cfgWord_t farTab [NumFrames];
	logic [DataBits-1:0] expData [NumFrames];
	logic [StrobeBits-1:0] expStrobe [NumFrames];

	int seed;
	int strobeCycles = 0;
	logic [StrobeBits-1:0] strobeSeen;

	clkGen #(.ResetCycles(5)) clkGen_i (.clk_o(clk), .rstN_o(rstN));

	eFpgaConfigTop #(
		.NumberOfRows(NumRows),
		.NumberOfCols(NumCols),
		.MaxFramesPerCol(FramesPerCol),
		.CfgAddr(CfgAddr)
	) dut_i (
		.wb_clk_i(clk), .rstN_i(rstN),
		.wbsStb_i(wbsStb), .wbsCyc_i(wbsCyc), .wbsWe_i(wbsWe), .wbsSel_i(wbsSel),
		.wbsAdr_i(wbsAdr), .wbsDat_i(wbsDatIn), .wbsAck_o(wbsAck), .wbsDat_o(wbsDatOut),
		.sClk_i(sClk), .sData_i(sData),
		.frameData_o(frameData), .frameStrobe_o(frameStrobe)
	);

	// low FAR bits land on the column named by the top field
	function automatic logic [StrobeBits-1:0] refStrobe(eFpgaCfgPkg::cfgWord_t far);
		int col;
		logic [StrobeBits-1:0] strobe;
		col = int'(far[WordBits-1 -: eFpgaCfgPkg::FrameSelectWidth]);
		strobe = '0;
		if (col < NumCols)
			strobe[col*FramesPerCol +: FramesPerCol] = far[FramesPerCol-1:0];
		return strobe;
	endfunction

	task automatic stopRun(string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic checkValue(string test, logic [DataBits-1:0] expected,
			logic [DataBits-1:0] actual);
		assert (actual === expected)
		else stopRun($sformatf("FAIL %s: expected %h, actual %h", test, expected, actual));
	endtask

	task automatic setEntry(int idx, bit fSrc, bit rSrc, eFpgaCfgPkg::cfgWord_t far);
		farSrc[idx] = fSrc;
		rowSrc[idx] = rSrc;
		farTab[idx] = far;
		expStrobe[idx] = refStrobe(far);
		for (int r = 0; r < NumRows; r++)
			expData[idx][r*WordBits +: WordBits] = $random(seed);
	endtask

	task automatic wbCycle(input bit we, input eFpgaCfgPkg::wbAddr_t adr,
			input eFpgaCfgPkg::cfgWord_t dat, input logic [WordBits/8-1:0] sel,
			output eFpgaCfgPkg::cfgWord_t rdat);
		@(negedge clk);
		wbsStb = 1'b1;
		wbsCyc = 1'b1;
		wbsWe = we;
		wbsSel = sel;
		wbsAdr = adr;
		wbsDatIn = dat;
		do
			@(negedge clk);
		while (!wbsAck);	// stb held until the slave acks
		rdat = wbsDatOut;
		wbsStb = 1'b0;
		wbsCyc = 1'b0;
		wbsWe = 1'b0;
	endtask

	task automatic sendSerial(eFpgaCfgPkg::cfgWord_t word);
		for (int b = WordBits - 1; b >= 0; b--) begin
			@(negedge clk);
			sClk = 1'b0;
			sData = word[b];
			repeat (2) @(negedge clk);
			sClk = 1'b1;	// loader samples sData on this rise
			@(negedge clk);
		end
		// the pins have no handshake so the word gets time to reach the sequencer
		repeat (SerialSettle) @(negedge clk);
	endtask

	task automatic sendWord(bit src, eFpgaCfgPkg::cfgWord_t word);
		eFpgaCfgPkg::cfgWord_t unused;
		if (src == SrcBb)
			sendSerial(word);
		else
			wbCycle(1'b1, CfgAddr, word, '1, unused);
	endtask

	task automatic runFrame(int idx);
		int startCount;
		int waitCycles;
		string name;
		name = $sformatf("frame %0d", idx);
		startCount = strobeCycles;
		sendWord(farSrc[idx], farTab[idx]);
		for (int r = 0; r < NumRows; r++)
			sendWord(rowSrc[idx], expData[idx][r*WordBits +: WordBits]);
		waitCycles = 0;
		while (frameData !== expData[idx] && waitCycles < 64) begin
			@(negedge clk);
			waitCycles++;
		end
		repeat (4) @(negedge clk);	// strobe is over by now
		checkValue({name, " frameData"}, expData[idx], frameData);
		checkValue({name, " strobe cycles"}, DataBits'(expStrobe[idx] != '0),
			DataBits'(strobeCycles - startCount));
		if (expStrobe[idx] != '0)
			checkValue({name, " frameStrobe"}, DataBits'(expStrobe[idx]), DataBits'(strobeSeen));
	endtask

	task automatic probeBus(eFpgaCfgPkg::cfgWord_t lastFar);
		eFpgaCfgPkg::cfgWord_t rdat;
		wbCycle(1'b0, CfgAddr, '0, '1, rdat);
		checkValue("read FAR", DataBits'(lastFar), DataBits'(rdat));
		wbCycle(1'b0, CfgAddr + 32'h4, '0, '1, rdat);
		checkValue("read other address", '0, DataBits'(rdat));
		// partial select gets an ack and nothing else
		wbCycle(1'b1, CfgAddr, 32'hdead_beef, 4'b0011, rdat);
		wbCycle(1'b0, CfgAddr, '0, '1, rdat);
		checkValue("FAR after partial write", DataBits'(lastFar), DataBits'(rdat));
	endtask

	always @(negedge clk) begin
		if (frameStrobe != '0) begin
			strobeCycles = strobeCycles + 1;
			strobeSeen = frameStrobe;
		end
	end

	initial begin
		wbsStb = 1'b0;
		wbsCyc = 1'b0;
		wbsWe = 1'b0;
		wbsSel = '0;
		wbsAdr = '0;
		wbsDatIn = '0;
		sClk = 1'b0;
		sData = 1'b0;
		seed = 32'h4fc8;
		setEntry(0, SrcWb, SrcWb, 32'h0800_00a5);	// column 1
		setEntry(1, SrcBb, SrcBb, 32'h1800_003c);	// column 3
		setEntry(2, SrcBb, SrcWb, 32'h0000_0081);
		setEntry(3, SrcBb, SrcWb, 32'h2800_0011);	// column 5 is past the last one
		setEntry(4, SrcWb, SrcWb, 32'h1000_0042);
		@(posedge rstN);
		@(negedge clk);
		checkValue("reset frameData", '0, frameData);
		checkValue("reset frameStrobe", '0, DataBits'(frameStrobe));
		for (int i = 0; i < NumFrames; i++) begin
			if (i == ProbeIdx)
				probeBus(farTab[i-1]);
			runFrame(i);
		end
		$display("Test OK");
		$finish;
	end

	initial begin
		repeat (WatchdogCycles) @(posedge clk);
		stopRun($sformatf("watchdog expired after %0d cycles, run did not finish",
			WatchdogCycles));
	end

endmodule

/* eFpgaConfig.f */
rtl/eFpgaCfgPkg.sv
rtl/frameBusIf.sv
rtl/wbConfigPort.sv
rtl/bitbangLoader.sv
rtl/configArbiter.sv
rtl/frameSequencer.sv
rtl/frameStore.sv
rtl/eFpgaConfigTop.sv
sim/clkGen.sv
sim/frameSequencer_checker.sv
sim/eFpgaConfigTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module eFpgaConfigTb -f eFpgaConfig.f -o eFpgaConfigSim
./obj_dir/eFpgaConfigSim
